// File: logic/dmc_cfg.svh
`ifndef DMC_CFG_SVH
`define DMC_CFG_SVH

// DFI data path
`define DMC_DFI_DATA_W 16
`define DMC_BURST_LEN 4

// Address geometry
`define DMC_COL_W 10
`define DMC_BANK_W 3
`define DMC_ROW_W 14

`define DMC_QUEUE_DEPTH 4

// DRAM timings in DFI clock cycles
`define DMC_TRP 3
`define DMC_TRCD 3
`define DMC_TRAS 6
`define DMC_TRC 9
`define DMC_TRFC 10
`define DMC_TMRD 2
`define DMC_TWR 3
`define DMC_TWTR 2
`define DMC_TRTP 2
`define DMC_TRRD 2
`define DMC_TCAS 3

`define DMC_TREFI 400

`endif

// File: logic/dmc_pkg.sv
`include "dmc_cfg.svh"

package dmc_pkg;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    LMR      = 4'b0000,
    REF      = 4'b0001,
    PRE      = 4'b0010,
    ACT      = 4'b0011,
    WRITE    = 4'b0100,
    READ     = 4'b0101,
    NOP      = 4'b0111,
    DESELECT = 4'b1111
  } dfi_cmd_e;

  typedef enum logic {
    WR = 1'b0,
    RD = 1'b1
  } app_cmd_e;

  typedef logic [`DMC_BANK_W-1:0] bank_t;
  typedef logic [`DMC_ROW_W-1:0]  row_t;
  typedef logic [`DMC_COL_W-1:0]  col_t;

  typedef struct packed {
    row_t  row;
    bank_t bank;
    col_t  col;
  } app_addr_t;

  typedef logic [15:0]                  dfi_addr_t;
  typedef logic [`DMC_DFI_DATA_W-1:0]   dfi_data_t;
  typedef logic [`DMC_DFI_DATA_W/8-1:0] dfi_mask_t;

  // Beat 0 sits in the low bits and goes out first
  typedef dfi_data_t [`DMC_BURST_LEN-1:0] data_burst_t;
  typedef dfi_mask_t [`DMC_BURST_LEN-1:0] mask_burst_t;

  typedef struct packed {
    dfi_cmd_e  cmd;
    bank_t     bank;
    dfi_addr_t addr;
  } dfi_cmd_s;

  typedef struct packed {
    dfi_cmd_s    dfi;
    data_burst_t wdata;
    mask_burst_t wmask;
  } dmc_entry_s;

  // A10 high on PRE closes every bank
  localparam dfi_addr_t PRE_ALL_ADDR = 16'h0400;

endpackage

// File: logic/dmc_cmd_fsm.sv
`timescale 1ns/10ps
`include "dmc_cfg.svh"

module dmc_cmd_fsm (
  input  logic                 dfi_clk_i,
  input  logic                 dfi_clk_sync_rst_i,
  input  logic                 app_en_i,
  input  dmc_pkg::app_cmd_e    app_cmd_i,
  input  dmc_pkg::app_addr_t   app_addr_i,
  input  dmc_pkg::data_burst_t app_wdf_data_i,
  input  dmc_pkg::mask_burst_t app_wdf_mask_i,
  input  logic                 not_full_i,
  output logic                 app_rdy_o,
  output logic                 init_calib_complete_o,
  output logic                 push_o,
  output dmc_pkg::dmc_entry_s  entry_o
);

  import dmc_pkg::*;

  typedef enum logic [1:0] {IDLE, INIT, REFR, LDST} state_e;

  localparam int REFI_W    = $clog2(`DMC_TREFI + 1);
  localparam int NUM_BANKS = 1 << `DMC_BANK_W;

  state_e               state_q;
  logic [1:0]           step_q;
  logic [REFI_W-1:0]    refi_cnt;
  logic                 refr_req;
  logic                 accept;
  logic                 last_step;
  app_cmd_e             req_cmd;
  app_addr_t            req_addr;
  data_burst_t          req_data;
  mask_burst_t          req_mask;
  logic [NUM_BANKS-1:0] open_bank;
  row_t                 open_row [NUM_BANKS];

  assign app_rdy_o = init_calib_complete_o && state_q == IDLE && !refr_req;
  assign accept    = app_en_i && app_rdy_o;
  assign push_o    = state_q != IDLE && not_full_i;
  assign last_step = push_o && step_q == 2'd0;

  // Steps count down and the last push of a sequence returns to IDLE
  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      state_q <= IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (!init_calib_complete_o) begin
            state_q <= INIT;
            step_q  <= 2'd3;
          end else if (refr_req) begin
            state_q <= REFR;
            step_q  <= (|open_bank) ? 2'd1 : 2'd0;
          end else if (accept) begin
            state_q <= LDST;
            if (!open_bank[app_addr_i.bank])
              step_q <= 2'd1;
            else if (open_row[app_addr_i.bank] == app_addr_i.row)
              step_q <= 2'd0;
            else
              step_q <= 2'd2;
          end
        end
        default: begin
          if (last_step)
            state_q <= IDLE;
          else if (push_o)
            step_q <= step_q - 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i)
      init_calib_complete_o <= 1'b0;
    else if (state_q == INIT && last_step)
      init_calib_complete_o <= 1'b1;
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      refi_cnt <= '0;
      refr_req <= 1'b0;
    end else if (init_calib_complete_o) begin
      if (state_q == REFR && last_step)
        refr_req <= 1'b0;
      // A new interval wins over a clear in the same cycle
      if (refi_cnt == REFI_W'(`DMC_TREFI)) begin
        refi_cnt <= '0;
        refr_req <= 1'b1;
      end else begin
        refi_cnt <= refi_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (accept) begin
      req_cmd  <= app_cmd_i;
      req_addr <= app_addr_i;
      req_data <= app_wdf_data_i;
      req_mask <= app_wdf_mask_i;
    end
  end

  always_comb begin
    entry_o         = '0;
    entry_o.dfi.cmd = DESELECT;
    entry_o.wdata   = req_data;
    entry_o.wmask   = req_mask;
    case (state_q)
      INIT: begin
        case (step_q)
          2'd3: begin
            entry_o.dfi.cmd  = PRE;
            entry_o.dfi.addr = PRE_ALL_ADDR;
          end
          2'd2, 2'd1:
            entry_o.dfi.cmd = REF;
          default: begin
            // CAS latency in A[7:4], burst code in A[3:0]
            entry_o.dfi.cmd  = LMR;
            entry_o.dfi.addr = {8'h0, 4'(`DMC_TCAS), 4'($clog2(`DMC_BURST_LEN * 2))};
          end
        endcase
      end
      REFR: begin
        if (step_q == 2'd1) begin
          entry_o.dfi.cmd  = PRE;
          entry_o.dfi.addr = PRE_ALL_ADDR;
        end else begin
          entry_o.dfi.cmd = REF;
        end
      end
      LDST: begin
        entry_o.dfi.bank = req_addr.bank;
        case (step_q)
          2'd2:
            entry_o.dfi.cmd = PRE;
          2'd1: begin
            entry_o.dfi.cmd  = ACT;
            entry_o.dfi.addr = dfi_addr_t'(req_addr.row);
          end
          default: begin
            entry_o.dfi.cmd  = (req_cmd == RD) ? READ : WRITE;
            entry_o.dfi.addr = dfi_addr_t'(req_addr.col);
          end
        endcase
      end
      default: ;
    endcase
  end

  // Row state follows what is pushed, not what is issued
  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      open_bank <= '0;
    end else if (push_o) begin
      case (entry_o.dfi.cmd)
        ACT:
          open_bank[entry_o.dfi.bank] <= 1'b1;
        PRE: begin
          if (entry_o.dfi.addr == PRE_ALL_ADDR)
            open_bank <= '0;
          else
            open_bank[entry_o.dfi.bank] <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (push_o && entry_o.dfi.cmd == ACT)
      open_row[entry_o.dfi.bank] <= req_addr.row;
  end

  // A full queue stalls the sequence on its current step
  assert property (@(posedge dfi_clk_i) disable iff (dfi_clk_sync_rst_i)
    (state_q != IDLE && !not_full_i) |=> $stable({state_q, step_q}))
    else $error("sequence advanced while the queue was full");

endmodule

// File: logic/dmc_cmd_queue.sv
`timescale 1ns/10ps
`include "dmc_cfg.svh"

module dmc_cmd_queue (
  input  logic                dfi_clk_i,
  input  logic                dfi_clk_sync_rst_i,
  input  logic                push_i,
  input  dmc_pkg::dmc_entry_s entry_i,
  input  logic                pop_i,
  output logic                not_full_o,
  output logic                head_valid_o,
  output dmc_pkg::dmc_entry_s head_o
);

  import dmc_pkg::*;

  localparam int PTR_W = $clog2(`DMC_QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`DMC_QUEUE_DEPTH + 1);

  dmc_entry_s       mem [`DMC_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign head_o       = mem[rd_ptr];
  assign head_valid_o = count != '0;
  assign not_full_o   = count != CNT_W'(`DMC_QUEUE_DEPTH);

  always_ff @(posedge dfi_clk_i) begin
    if (push_i)
      mem[wr_ptr] <= entry_i;
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i)
        wr_ptr <= (wr_ptr == PTR_W'(`DMC_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop_i)
        rd_ptr <= (rd_ptr == PTR_W'(`DMC_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assert property (@(posedge dfi_clk_i) disable iff (dfi_clk_sync_rst_i)
    pop_i |-> head_valid_o)
    else $error("issue stage popped an empty queue");

  assert property (@(posedge dfi_clk_i) disable iff (dfi_clk_sync_rst_i)
    push_i |-> not_full_o)
    else $error("FSM pushed into a full queue");

endmodule

// File: logic/dmc_cmd_issue.sv
`timescale 1ns/10ps
`include "dmc_cfg.svh"

module dmc_cmd_issue (
  input  logic               dfi_clk_i,
  input  logic               dfi_clk_sync_rst_i,
  input  logic               head_valid_i,
  input  dmc_pkg::dfi_cmd_s  head_i,
  output logic               pop_o,
  output logic               wr_start_o,
  output dmc_pkg::dfi_cmd_e  dfi_cmd_o,
  output dmc_pkg::bank_t     dfi_bank_o,
  output dmc_pkg::dfi_addr_t dfi_address_o,
  output logic               dfi_cke_o,
  output logic               dfi_rddata_en_o
);

  import dmc_pkg::*;

  localparam int TICK_W = 6;
  localparam int CAS_W  = $clog2(`DMC_TCAS + 1);
  localparam int BL_W   = $clog2(`DMC_BURST_LEN);
  // Write recovery runs from the last data beat on the DFI
  localparam int WR_REC = `DMC_BURST_LEN + 1 + `DMC_TWR;

  dfi_cmd_e          nxt;
  dfi_cmd_e          last_cmd;
  logic              timing_ok;
  logic              col_ok;
  logic              issue;
  logic [TICK_W-1:0] cmd_tick, act_tick, wr_tick, rd_tick;
  logic              cas_valid;
  logic [CAS_W-1:0]  cas_tick;
  logic [BL_W-1:0]   rburst_tick;

  // Cycles since the event, one in the cycle after it, saturating
  function automatic logic [TICK_W-1:0] tick_next(logic [TICK_W-1:0] t, logic clr);
    if (clr)
      return TICK_W'(1);
    return (&t) ? t : t + 1'b1;
  endfunction

  assign nxt        = head_i.cmd;
  assign col_ok     = wr_tick >= `DMC_BURST_LEN && rd_tick >= `DMC_BURST_LEN;
  assign issue      = dfi_cke_o && head_valid_i && timing_ok;
  assign pop_o      = issue;
  assign wr_start_o = issue && nxt == WRITE;

  always_comb begin
    timing_ok = 1'b1;
    case (last_cmd)
      PRE:     timing_ok = cmd_tick >= `DMC_TRP;
      REF:     timing_ok = cmd_tick >= `DMC_TRFC;
      LMR:     timing_ok = cmd_tick >= `DMC_TMRD;
      default: ;
    endcase
    case (nxt)
      ACT:
        timing_ok &= act_tick >= `DMC_TRRD && act_tick >= `DMC_TRC;
      PRE:
        timing_ok &= act_tick >= `DMC_TRAS && wr_tick >= WR_REC && rd_tick >= `DMC_TRTP;
      READ:
        timing_ok &= act_tick >= `DMC_TRCD && col_ok && wr_tick >= `DMC_TWTR;
      WRITE:
        timing_ok &= act_tick >= `DMC_TRCD && col_ok &&
                     rd_tick >= `DMC_TCAS + `DMC_BURST_LEN;
      default: ;
    endcase
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      cmd_tick <= '1;
      act_tick <= '1;
      wr_tick  <= '1;
      rd_tick  <= '1;
      last_cmd <= NOP;
    end else begin
      cmd_tick <= tick_next(cmd_tick, issue);
      act_tick <= tick_next(act_tick, issue && nxt == ACT);
      wr_tick  <= tick_next(wr_tick, issue && nxt == WRITE);
      rd_tick  <= tick_next(rd_tick, issue && nxt == READ);
      if (issue)
        last_cmd <= nxt;
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      dfi_cmd_o <= DESELECT;
      dfi_cke_o <= 1'b0;
    end else begin
      dfi_cmd_o <= issue ? nxt : DESELECT;
      dfi_cke_o <= 1'b1;
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (issue) begin
      dfi_bank_o    <= head_i.bank;
      dfi_address_o <= head_i.addr;
    end
  end

  // CAS countdown from the READ, then one enable per beat
  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      cas_valid <= 1'b0;
      cas_tick  <= '0;
    end else if (issue && nxt == READ) begin
      cas_valid <= 1'b1;
      cas_tick  <= CAS_W'(`DMC_TCAS - 1);
    end else if (cas_valid) begin
      cas_tick <= cas_tick - 1'b1;
      if (cas_tick == '0)
        cas_valid <= 1'b0;
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      dfi_rddata_en_o <= 1'b0;
      rburst_tick     <= '0;
    end else if (cas_valid && cas_tick == '0) begin
      dfi_rddata_en_o <= 1'b1;
      rburst_tick     <= BL_W'(`DMC_BURST_LEN - 1);
    end else if (dfi_rddata_en_o) begin
      rburst_tick <= rburst_tick - 1'b1;
      if (rburst_tick == '0)
        dfi_rddata_en_o <= 1'b0;
    end
  end

endmodule

// File: logic/dmc_burst_serializer.sv
`timescale 1ns/10ps
`include "dmc_cfg.svh"

module dmc_burst_serializer #(
  parameter type beat_t = dmc_pkg::dfi_data_t
) (
  input  logic                       dfi_clk_i,
  input  logic                       dfi_clk_sync_rst_i,
  input  logic                       start_i,
  input  beat_t [`DMC_BURST_LEN-1:0] burst_i,
  output logic                       valid_o,
  output beat_t                      beat_o
);

  localparam int CNT_W = $clog2(`DMC_BURST_LEN);

  logic                       start_q;
  beat_t [`DMC_BURST_LEN-1:0] burst_q;
  beat_t [`DMC_BURST_LEN-1:0] shift_q;
  logic [CNT_W-1:0]           cnt;

  assign beat_o = shift_q[0];

  // Loading one cycle after start puts beat 0 two cycles after the WRITE
  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      start_q <= 1'b0;
      valid_o <= 1'b0;
      cnt     <= '0;
    end else begin
      start_q <= start_i;
      if (start_q) begin
        valid_o <= 1'b1;
        cnt     <= CNT_W'(`DMC_BURST_LEN - 1);
      end else if (valid_o) begin
        cnt <= cnt - 1'b1;
        if (cnt == '0)
          valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (start_i)
      burst_q <= burst_i;
    if (start_q)
      shift_q <= burst_q;
    else if (valid_o)
      shift_q <= shift_q >> $bits(beat_t);
  end

  // Back to back bursts may only start in the last two beats of the one before
  assert property (@(posedge dfi_clk_i) disable iff (dfi_clk_sync_rst_i)
    start_i |-> !start_q && !(valid_o && cnt > 1))
    else $error("new burst started while the previous one was shifting");

endmodule

// File: logic/dmc_rd_burst_collector.sv
`timescale 1ns/10ps
`include "dmc_cfg.svh"

module dmc_rd_burst_collector (
  input  logic                 dfi_clk_i,
  input  logic                 dfi_clk_sync_rst_i,
  input  logic                 beat_valid_i,
  input  dmc_pkg::dfi_data_t   beat_i,
  output logic                 burst_valid_o,
  output dmc_pkg::data_burst_t burst_o
);

  localparam int CNT_W = $clog2(`DMC_BURST_LEN);

  logic [CNT_W-1:0] cnt;
  logic             last_beat;

  assign last_beat = cnt == CNT_W'(`DMC_BURST_LEN - 1);

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      cnt           <= '0;
      burst_valid_o <= 1'b0;
    end else begin
      burst_valid_o <= beat_valid_i && last_beat;
      if (beat_valid_i)
        cnt <= last_beat ? '0 : cnt + 1'b1;
    end
  end

  // Beats land in request order, slot 0 first
  always_ff @(posedge dfi_clk_i) begin
    if (beat_valid_i)
      burst_o[cnt] <= beat_i;
  end

endmodule

// File: logic/dmc_controller.sv
`timescale 1ns/10ps

module dmc_controller (
  input  logic                 dfi_clk_i,
  input  logic                 dfi_clk_sync_rst_i,
  input  logic                 app_en_i,
  input  dmc_pkg::app_cmd_e    app_cmd_i,
  input  dmc_pkg::app_addr_t   app_addr_i,
  input  dmc_pkg::data_burst_t app_wdf_data_i,
  input  dmc_pkg::mask_burst_t app_wdf_mask_i,
  output logic                 app_rdy_o,
  output logic                 app_rd_data_valid_o,
  output dmc_pkg::data_burst_t app_rd_data_o,
  output logic                 init_calib_complete_o,
  output dmc_pkg::dfi_cmd_e    dfi_cmd_o,
  output dmc_pkg::bank_t       dfi_bank_o,
  output dmc_pkg::dfi_addr_t   dfi_address_o,
  output logic                 dfi_cke_o,
  output logic                 dfi_wrdata_en_o,
  output dmc_pkg::dfi_data_t   dfi_wrdata_o,
  output dmc_pkg::dfi_mask_t   dfi_wrdata_mask_o,
  output logic                 dfi_rddata_en_o,
  input  dmc_pkg::dfi_data_t   dfi_rddata_i,
  input  logic                 dfi_rddata_valid_i
);

  import dmc_pkg::*;

  logic       push;
  logic       not_full;
  dmc_entry_s push_entry;
  logic       head_valid;
  dmc_entry_s head;
  logic       pop;
  logic       wr_start;

  dmc_cmd_fsm u_cmd_fsm (
    .dfi_clk_i             (dfi_clk_i),
    .dfi_clk_sync_rst_i    (dfi_clk_sync_rst_i),
    .app_en_i              (app_en_i),
    .app_cmd_i             (app_cmd_i),
    .app_addr_i            (app_addr_i),
    .app_wdf_data_i        (app_wdf_data_i),
    .app_wdf_mask_i        (app_wdf_mask_i),
    .not_full_i            (not_full),
    .app_rdy_o             (app_rdy_o),
    .init_calib_complete_o (init_calib_complete_o),
    .push_o                (push),
    .entry_o               (push_entry)
  );

  dmc_cmd_queue u_cmd_queue (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .push_i             (push),
    .entry_i            (push_entry),
    .pop_i              (pop),
    .not_full_o         (not_full),
    .head_valid_o       (head_valid),
    .head_o             (head)
  );

  dmc_cmd_issue u_cmd_issue (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .head_valid_i       (head_valid),
    .head_i             (head.dfi),
    .pop_o              (pop),
    .wr_start_o         (wr_start),
    .dfi_cmd_o          (dfi_cmd_o),
    .dfi_bank_o         (dfi_bank_o),
    .dfi_address_o      (dfi_address_o),
    .dfi_cke_o          (dfi_cke_o),
    .dfi_rddata_en_o    (dfi_rddata_en_o)
  );

  // Head burst is valid in the cycle the WRITE is issued
  dmc_burst_serializer #(.beat_t(dfi_data_t)) u_wdata_ser (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .start_i            (wr_start),
    .burst_i            (head.wdata),
    .valid_o            (dfi_wrdata_en_o),
    .beat_o             (dfi_wrdata_o)
  );

  dmc_burst_serializer #(.beat_t(dfi_mask_t)) u_wmask_ser (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .start_i            (wr_start),
    .burst_i            (head.wmask),
    .valid_o            (),
    .beat_o             (dfi_wrdata_mask_o)
  );

  dmc_rd_burst_collector u_rd_collector (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .beat_valid_i       (dfi_rddata_valid_i),
    .beat_i             (dfi_rddata_i),
    .burst_valid_o      (app_rd_data_valid_o),
    .burst_o            (app_rd_data_o)
  );

endmodule

// File: testbench/tb_dmc_controller.sv
`timescale 1ns/10ps
`include "dmc_cfg.svh"

module tb_dmc_controller;

  import dmc_pkg::*;

  localparam int BL        = `DMC_BURST_LEN;
  localparam int NUM_TESTS = 12;
  // CAS latency in A[7:4], burst code log2(BL)+1 in A[3:0]
  localparam dfi_addr_t LMR_ADDR = {8'h00, 4'(`DMC_TCAS), 4'($clog2(`DMC_BURST_LEN) + 1)};

  typedef struct {
    string       name;
    app_cmd_e    cmd;
    app_addr_t   addr;
    data_burst_t wdata;
    mask_burst_t wmask;
    bit          chain;
    bit          wait_ref;
  } test_s;

  logic        dfi_clk_i = 1'b0;
  logic        dfi_clk_sync_rst_i;
  logic        app_en_i;
  app_cmd_e    app_cmd_i;
  app_addr_t   app_addr_i;
  data_burst_t app_wdf_data_i;
  mask_burst_t app_wdf_mask_i;
  logic        app_rdy_o;
  logic        app_rd_data_valid_o;
  data_burst_t app_rd_data_o;
  logic        init_calib_complete_o;
  dfi_cmd_e    dfi_cmd_o;
  bank_t       dfi_bank_o;
  dfi_addr_t   dfi_address_o;
  logic        dfi_cke_o;
  logic        dfi_wrdata_en_o;
  dfi_data_t   dfi_wrdata_o;
  dfi_mask_t   dfi_wrdata_mask_o;
  logic        dfi_rddata_en_o;
  dfi_data_t   dfi_rddata_i;
  logic        dfi_rddata_valid_i;

  test_s       tests [NUM_TESTS];
  data_burst_t init_mem [app_addr_t];
  data_burst_t ref_mem [app_addr_t];
  data_burst_t model_mem [app_addr_t];
  app_addr_t   wq [$];
  app_addr_t   rq [$];
  data_burst_t exp_q [$];
  string       name_q [$];
  logic [7:0]  model_open;
  row_t        model_row [8];
  logic [7:0]  tb_open;
  row_t        tb_row [8];
  bit          exp_wr_en [64];
  bit          exp_rd_en [64];
  int          errors;
  int          ref_count;
  int          cyc;
  int          last_any, last_act, last_wr, last_rd, last_ref;
  dfi_cmd_e    last_cmd;
  string       cur_name;
  int          wbeat, rbeat;
  app_addr_t   mkey;
  data_burst_t mbuf;

  dmc_controller dut_i (.*);

  always #20 dfi_clk_i = ~dfi_clk_i;

  task automatic check_burst(string name, data_burst_t exp, data_burst_t act);
    if (exp !== act) begin
      errors++;
      $display("** Error %s: read burst expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_cmd(string name, dfi_cmd_e exp, dfi_cmd_e act);
    if (exp !== act) begin
      errors++;
      $display("** Error %s: command expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_addr(string name, dfi_addr_t exp, dfi_addr_t act);
    if (exp !== act) begin
      errors++;
      $display("** Error %s: DFI address expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_gap(string rule, int gap, int min_gap);
    if (gap < min_gap) begin
      errors++;
      $display("** Error %s: %s gap expected >= %0d, actual %0d", cur_name, rule, min_gap, gap);
    end
  endtask

  function automatic bit is_traffic(dfi_cmd_e c, dfi_addr_t a);
    return !(c == DESELECT || c == NOP || c == REF || (c == PRE && a == PRE_ALL_ADDR));
  endfunction

  function automatic app_addr_t mk_addr(int row, int bank, int col);
    return {row_t'(row), bank_t'(bank), col_t'(col)};
  endfunction

  function automatic data_burst_t fill_pattern(app_addr_t a);
    return {a ^ 27'h5a5a5a5, 10'h0, a};
  endfunction

  task automatic set_test(int i, string name, app_cmd_e cmd, app_addr_t addr,
                          data_burst_t wdata, mask_burst_t wmask, bit chain, bit wait_ref);
    tests[i] = '{name, cmd, addr, wdata, wmask, chain, wait_ref};
  endtask

  // Timing monitor and DRAM row tracking
  always @(posedge dfi_clk_i) begin
    cyc++;
    if (!dfi_clk_sync_rst_i) begin
      if (dfi_wrdata_en_o !== exp_wr_en[cyc % 64]) begin
        errors++;
        $display("** Error %s: dfi_wrdata_en_o expected %0b, actual %0b",
                 cur_name, exp_wr_en[cyc % 64], dfi_wrdata_en_o);
      end
      if (dfi_rddata_en_o !== exp_rd_en[cyc % 64]) begin
        errors++;
        $display("** Error %s: dfi_rddata_en_o expected %0b, actual %0b",
                 cur_name, exp_rd_en[cyc % 64], dfi_rddata_en_o);
      end
      exp_wr_en[cyc % 64] = 1'b0;
      exp_rd_en[cyc % 64] = 1'b0;
      if (dfi_cmd_o != DESELECT && dfi_cmd_o != NOP) begin
        case (last_cmd)
          PRE:     check_gap("tRP", cyc - last_any, `DMC_TRP);
          REF:     check_gap("tRFC", cyc - last_any, `DMC_TRFC);
          LMR:     check_gap("tMRD", cyc - last_any, `DMC_TMRD);
          default: ;
        endcase
        case (dfi_cmd_o)
          ACT: begin
            check_gap("tRRD", cyc - last_act, `DMC_TRRD);
            check_gap("tRC", cyc - last_act, `DMC_TRC);
            model_open[dfi_bank_o] = 1'b1;
            model_row[dfi_bank_o] = row_t'(dfi_address_o);
            last_act = cyc;
          end
          PRE: begin
            check_gap("tRAS", cyc - last_act, `DMC_TRAS);
            check_gap("tWR", cyc - last_wr, `DMC_TWR);
            check_gap("tRTP", cyc - last_rd, `DMC_TRTP);
            if (dfi_address_o == PRE_ALL_ADDR)
              model_open = '0;
            else
              model_open[dfi_bank_o] = 1'b0;
          end
          REF: begin
            if (|model_open) begin
              errors++;
              $display("%s: refresh issued while a bank was still open", cur_name);
            end
            ref_count++;
            last_ref = cyc;
            tb_open = '0;
          end
          WRITE: begin
            check_gap("tRCD", cyc - last_act, `DMC_TRCD);
            check_gap("col to col", cyc - last_wr, BL);
            check_gap("col to col", cyc - last_rd, BL);
            check_gap("read to write", cyc - last_rd, `DMC_TCAS + BL);
            wq.push_back({model_row[dfi_bank_o], dfi_bank_o, col_t'(dfi_address_o)});
            for (int k = 1; k <= BL; k++)
              exp_wr_en[(cyc + k) % 64] = 1'b1;
            last_wr = cyc;
          end
          READ: begin
            check_gap("tRCD", cyc - last_act, `DMC_TRCD);
            check_gap("col to col", cyc - last_wr, BL);
            check_gap("col to col", cyc - last_rd, BL);
            check_gap("tWTR", cyc - last_wr, `DMC_TWTR);
            rq.push_back({model_row[dfi_bank_o], dfi_bank_o, col_t'(dfi_address_o)});
            for (int k = 0; k < BL; k++)
              exp_rd_en[(cyc + `DMC_TCAS + k) % 64] = 1'b1;
            last_rd = cyc;
          end
          default: ;
        endcase
        last_cmd = dfi_cmd_o;
        last_any = cyc;
      end
      if (init_calib_complete_o && cyc - last_ref > `DMC_TREFI + 100) begin
        errors++;
        $display("no refresh seen within %0d cycles", `DMC_TREFI + 100);
        last_ref = cyc;
      end
    end
  end

  // DRAM data side, masked bytes keep their old value
  always @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      dfi_rddata_valid_i <= 1'b0;
      wbeat = 0;
      rbeat = 0;
    end else begin
      if (dfi_wrdata_en_o && wq.size() > 0) begin
        mkey = wq[0];
        mbuf = model_mem.exists(mkey) ? model_mem[mkey] : fill_pattern(mkey);
        for (int j = 0; j < 2; j++)
          if (!dfi_wrdata_mask_o[j])
            mbuf[wbeat][j*8 +: 8] = dfi_wrdata_o[j*8 +: 8];
        model_mem[mkey] = mbuf;
        wbeat++;
        if (wbeat == BL) begin
          wbeat = 0;
          void'(wq.pop_front());
        end
      end
      if (dfi_rddata_en_o && rq.size() > 0) begin
        mkey = rq[0];
        mbuf = model_mem.exists(mkey) ? model_mem[mkey] : fill_pattern(mkey);
        dfi_rddata_i       <= mbuf[rbeat];
        dfi_rddata_valid_i <= 1'b1;
        rbeat++;
        if (rbeat == BL) begin
          rbeat = 0;
          void'(rq.pop_front());
        end
      end else begin
        dfi_rddata_valid_i <= 1'b0;
      end
    end
  end

  always @(posedge dfi_clk_i) begin
    if (!dfi_clk_sync_rst_i && app_rd_data_valid_o) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("read data returned with no read outstanding");
      end else begin
        check_burst(name_q[0], exp_q[0], app_rd_data_o);
        $display("test %s finished, %0d errors so far", name_q[0], errors);
        void'(exp_q.pop_front());
        void'(name_q.pop_front());
      end
    end
  end

  task automatic run_test(int i);
    dfi_cmd_e    pat [$];
    dfi_cmd_e    exp_pat [$];
    dfi_cmd_e    col;
    int          start_ref;
    app_addr_t   a;
    data_burst_t b;

    cur_name = tests[i].name;
    a = tests[i].addr;
    col = (tests[i].cmd == RD) ? READ : WRITE;
    if (tests[i].wait_ref) begin
      start_ref = ref_count;
      while (ref_count == start_ref)
        @(posedge dfi_clk_i);
    end
    @(posedge dfi_clk_i);
    app_en_i       <= 1'b1;
    app_cmd_i      <= tests[i].cmd;
    app_addr_i     <= a;
    app_wdf_data_i <= tests[i].wdata;
    app_wdf_mask_i <= tests[i].wmask;
    do @(posedge dfi_clk_i); while (!app_rdy_o);
    app_en_i <= 1'b0;
    do begin
      @(posedge dfi_clk_i);
      if (is_traffic(dfi_cmd_o, dfi_address_o))
        pat.push_back(dfi_cmd_o);
    end while ((pat.size() == 0 || pat[$] != col) && pat.size() < 4);
    // Row policy
    if (!tb_open[a.bank]) begin
      exp_pat = '{ACT, col};
    end else if (tb_row[a.bank] == a.row) begin
      exp_pat = '{col};
    end else begin
      exp_pat = '{PRE, ACT, col};
    end
    tb_open[a.bank] = 1'b1;
    tb_row[a.bank] = a.row;
    if (pat.size() != exp_pat.size()) begin
      errors++;
      $display("%s: %0d commands issued for the access, %0d expected",
               cur_name, pat.size(), exp_pat.size());
    end else begin
      foreach (pat[k])
        check_cmd(cur_name, exp_pat[k], pat[k]);
    end
    if (tests[i].cmd == WR) begin
      b = ref_mem[a];
      for (int n = 0; n < BL; n++)
        for (int j = 0; j < 2; j++)
          if (!tests[i].wmask[n][j])
            b[n][j*8 +: 8] = tests[i].wdata[n][j*8 +: 8];
      ref_mem[a] = b;
      while (!dfi_wrdata_en_o)
        @(posedge dfi_clk_i);
      while (dfi_wrdata_en_o)
        @(posedge dfi_clk_i);
      $display("test %s finished, %0d errors so far", cur_name, errors);
    end else begin
      exp_q.push_back(ref_mem[a]);
      name_q.push_back(cur_name);
      if (!tests[i].chain)
        while (exp_q.size() != 0)
          @(posedge dfi_clk_i);
    end
  endtask

  initial begin
    #((NUM_TESTS * 300 + 600) * 40);
    $display("watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    dfi_clk_sync_rst_i = 1'b1;
    app_en_i = 1'b0;
    app_cmd_i = RD;
    app_addr_i = '0;
    app_wdf_data_i = '0;
    app_wdf_mask_i = '0;
    dfi_rddata_i = '0;
    dfi_rddata_valid_i = 1'b0;
    errors = 0;
    ref_count = 0;
    cyc = 0;
    last_any = -1000;
    last_act = -1000;
    last_wr = -1000;
    last_rd = -1000;
    last_ref = 0;
    last_cmd = NOP;
    model_open = '0;
    tb_open = '0;
    cur_name = "reset";
    void'($urandom(24113));

    set_test(0, "wr_closed_bank", WR, mk_addr(5, 1, 8), 64'h1111_2222_3333_4444, 8'h00, 0, 0);
    set_test(1, "rd_same_row", RD, mk_addr(5, 1, 8), '0, '0, 0, 0);
    set_test(2, "wr_masked", WR, mk_addr(5, 1, 8), 64'haaaa_bbbb_cccc_dddd, 8'h5a, 0, 0);
    set_test(3, "rd_masked", RD, mk_addr(5, 1, 8), '0, '0, 0, 0);
    set_test(4, "rd_row_miss", RD, mk_addr(9, 1, 8), '0, '0, 0, 0);
    set_test(5, "rd_bank2", RD, mk_addr(3, 2, 16), '0, '0, 1, 0);
    set_test(6, "rd_bank3", RD, mk_addr(7, 3, 32), '0, '0, 1, 0);
    set_test(7, "rd_bank4", RD, mk_addr(1, 4, 40), '0, '0, 1, 0);
    set_test(8, "wr_bank2_hit", WR, mk_addr(3, 2, 16), 64'h0123_4567_89ab_cdef, 8'h81, 0, 0);
    set_test(9, "rd_bank2_hit", RD, mk_addr(3, 2, 16), '0, '0, 0, 0);
    set_test(10, "rd_after_refresh", RD, mk_addr(3, 2, 16), '0, '0, 0, 1);
    set_test(11, "rd_back_to_row5", RD, mk_addr(5, 1, 8), '0, '0, 0, 0);
    foreach (tests[i])
      if (!init_mem.exists(tests[i].addr))
        init_mem[tests[i].addr] = {$urandom(), $urandom()};
    ref_mem = init_mem;
    model_mem = init_mem;

    repeat (4) @(posedge dfi_clk_i);
    check_cmd("reset", DESELECT, dfi_cmd_o);
    if (app_rdy_o || init_calib_complete_o || app_rd_data_valid_o || dfi_wrdata_en_o ||
        dfi_rddata_en_o || dfi_cke_o) begin
      errors++;
      $display("an output was active during reset");
    end
    repeat (4) @(posedge dfi_clk_i);
    dfi_clk_sync_rst_i <= 1'b0;
    repeat (2) @(posedge dfi_clk_i);
    if (!dfi_cke_o) begin
      errors++;
      $display("dfi_cke_o did not rise after reset");
    end

    // Power-up sequence
    cur_name = "init";
    for (int n = 0; n < 4; n++) begin
      do @(posedge dfi_clk_i); while (dfi_cmd_o == DESELECT || dfi_cmd_o == NOP);
      case (n)
        0: begin
          check_cmd(cur_name, PRE, dfi_cmd_o);
          check_addr(cur_name, PRE_ALL_ADDR, dfi_address_o);
        end
        3: begin
          check_cmd(cur_name, LMR, dfi_cmd_o);
          check_addr(cur_name, LMR_ADDR, dfi_address_o);
        end
        default: check_cmd(cur_name, REF, dfi_cmd_o);
      endcase
    end
    while (!init_calib_complete_o)
      @(posedge dfi_clk_i);
    $display("test init finished, %0d errors so far", errors);

    for (int i = 0; i < NUM_TESTS; i++)
      run_test(i);
    while (exp_q.size() != 0)
      @(posedge dfi_clk_i);
    repeat (10) @(posedge dfi_clk_i);

    $display("%0d tests run, %0d errors", NUM_TESTS + 1, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+logic
logic/dmc_pkg.sv
logic/dmc_cmd_fsm.sv
logic/dmc_cmd_queue.sv
logic/dmc_cmd_issue.sv
logic/dmc_burst_serializer.sv
logic/dmc_rd_burst_collector.sv
logic/dmc_controller.sv
testbench/tb_dmc_controller.sv

// File: Bender.yml
package:
  name: dmc_controller

sources:
  - include_dirs:
      - logic
    files:
      - logic/dmc_pkg.sv
      - logic/dmc_cmd_fsm.sv
      - logic/dmc_cmd_queue.sv
      - logic/dmc_cmd_issue.sv
      - logic/dmc_burst_serializer.sv
      - logic/dmc_rd_burst_collector.sv
      - logic/dmc_controller.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_dmc_controller.sv
